// File: hdl/sram_fifo_pkg.sv
// sram_fifo_pkg
// shared constants and enumerations of the SRAM ring buffer FIFO
// widths, register map and read controller states
package sram_fifo_pkg;

    localparam int SRAM_ADDR_W = 20; // 1M halfwords max
    localparam int SRAM_DATA_W = 16;

    localparam int BUF_DEPTH = 16;  // input buffer, 32-bit words
    localparam int BUF_PTR_W = 4;

    // fill level in halfwords, one bit above the address
    localparam int SIZE_W = 21;

    // threshold reset values, in 1/256 of the SRAM depth
    localparam logic [7:0] ALMOST_FULL_DEFAULT  = 8'd242;
    localparam logic [7:0] ALMOST_EMPTY_DEFAULT = 8'd12;

    typedef enum logic [15:0] {
        REG_RESET  = 16'd0,
        REG_SIZE0  = 16'd1, // almost-full on write
        REG_SIZE1  = 16'd2, // almost-empty on write
        REG_SIZE2  = 16'd3,
        REG_ERRCNT = 16'd4
    } reg_addr_e;

    // encodings kept from the older controller
    typedef enum logic [1:0] {
        READ_WORD = 2'd0,
        READ_HOLD = 2'd2,
        READ_TRY  = 2'd3
    } read_state_e;

endpackage

// File: hdl/sram_fifo_regs.sv
// sram_fifo_regs
// 8-bit register bus of the SRAM FIFO: soft reset on address 0,
// almost-full / almost-empty thresholds, fill level readback in bytes,
// saturating read-error counter and the near-full flag with hysteresis
`timescale 1ns/100ps

module sram_fifo_regs #(
    parameter int SRAM_DEPTH = 1 << sram_fifo_pkg::SRAM_ADDR_W
) (
    input  logic                            BUS_CLK,
    input  logic                            RST,
    input  logic [15:0]                     bus_add,
    input  logic [7:0]                      bus_data_in,
    input  logic                            bus_wr,
    output logic [7:0]                      bus_data_out,
    output logic                            local_rst,
    input  logic [sram_fifo_pkg::SIZE_W-1:0] size,
    input  logic                            read_error_strobe,
    output logic                            fifo_near_full,
    output logic                            fifo_read_error
);

    logic        soft_rst;
    logic [7:0]  almost_full;
    logic [7:0]  almost_empty;
    logic [7:0]  err_cnt;
    logic [23:0] size_bytes;
    logic [31:0] full_level;
    logic [31:0] empty_level;

    assign soft_rst  = bus_wr && (bus_add == sram_fifo_pkg::REG_RESET);
    assign local_rst = RST || soft_rst;

    always_ff @(posedge BUS_CLK) begin
        if (local_rst) begin
            almost_full  <= sram_fifo_pkg::ALMOST_FULL_DEFAULT;
            almost_empty <= sram_fifo_pkg::ALMOST_EMPTY_DEFAULT;
        end else if (bus_wr) begin
            if (bus_add == sram_fifo_pkg::REG_SIZE0)
                almost_full <= bus_data_in;
            if (bus_add == sram_fifo_pkg::REG_SIZE1)
                almost_empty <= bus_data_in;
        end
    end

    // halfwords to bytes
    assign size_bytes = {2'b00, size, 1'b0};

    always_ff @(posedge BUS_CLK) begin
        if (local_rst) begin
            bus_data_out <= 8'h00;
        end else begin
            case (bus_add)
                sram_fifo_pkg::REG_SIZE0:  bus_data_out <= size_bytes[7:0];
                sram_fifo_pkg::REG_SIZE1:  bus_data_out <= size_bytes[15:8];
                sram_fifo_pkg::REG_SIZE2:  bus_data_out <= size_bytes[23:16];
                sram_fifo_pkg::REG_ERRCNT: bus_data_out <= err_cnt;
                default:                   bus_data_out <= 8'h00;
            endcase
        end
    end

    // read attempts on an empty FIFO, stuck at 255
    always_ff @(posedge BUS_CLK) begin
        if (local_rst)
            err_cnt <= 8'd0;
        else if (read_error_strobe && err_cnt != 8'hff)
            err_cnt <= err_cnt + 8'd1;
    end

    assign fifo_read_error = (err_cnt != 8'd0);

    // thresholds scaled to the SRAM depth
    assign full_level  = ((32'(almost_full) + 32'd1) * 32'(SRAM_DEPTH)) >> 8;
    assign empty_level = ((32'(almost_empty) + 32'd1) * 32'(SRAM_DEPTH)) >> 8;

    always_ff @(posedge BUS_CLK) begin
        if (local_rst)
            fifo_near_full <= 1'b0;
        else if (32'(size) >= full_level || almost_full == 8'd0)
            fifo_near_full <= 1'b1;
        else if ((32'(size) <= empty_level && almost_empty != 8'd0) || size == '0)
            fifo_near_full <= 1'b0; // between the levels the flag holds
    end

endmodule

// File: hdl/sram_fifo_inbuf.sv
// sram_fifo_inbuf
// small first-word-fall-through buffer for the 32-bit input stream,
// decouples the source from SRAM read cycles
`timescale 1ns/100ps

module sram_fifo_inbuf (
    input  logic        BUS_CLK,
    input  logic        local_rst,
    input  logic        wr_en,
    input  logic [31:0] din,
    input  logic        rd_en,
    output logic [31:0] dout,
    output logic        empty,
    output logic        full
);

    logic [31:0]                         mem [sram_fifo_pkg::BUF_DEPTH];
    logic [sram_fifo_pkg::BUF_PTR_W-1:0] wr_idx;
    logic [sram_fifo_pkg::BUF_PTR_W-1:0] rd_idx;
    logic [sram_fifo_pkg::BUF_PTR_W:0]   count;
    logic                                push;
    logic                                pop;

    assign push = wr_en && !full; // dropped when full
    assign pop  = rd_en && !empty;

    always_ff @(posedge BUS_CLK) begin
        if (push)
            mem[wr_idx] <= din;
    end

    always_ff @(posedge BUS_CLK) begin
        if (local_rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_idx <= wr_idx + 1'b1; // power of two, wraps by itself
            if (pop)
                rd_idx <= rd_idx + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // head word is visible without a read
    assign dout  = mem[rd_idx];
    assign empty = (count == '0);
    assign full  = (count == (sram_fifo_pkg::BUF_PTR_W + 1)'(sram_fifo_pkg::BUF_DEPTH));

endmodule

// File: hdl/sram_ptr_counter.sv
// sram_ptr_counter
// read and write pointers of the SRAM ring buffer, in halfwords
// empty/full from the pointers, full_reg computed one step ahead,
// registered fill size including a halfword held by the reader
`timescale 1ns/100ps

module sram_ptr_counter #(
    parameter int SRAM_DEPTH = 1 << sram_fifo_pkg::SRAM_ADDR_W
) (
    input  logic                                 BUS_CLK,
    input  logic                                 local_rst,
    input  logic                                 read_sram,
    input  logic                                 write_sram,
    output logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] rd_ptr,
    output logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] wr_ptr,
    output logic                                 empty,
    output logic                                 full,
    output logic                                 full_reg,
    input  logic                                 hold,
    output logic [sram_fifo_pkg::SIZE_W-1:0]      size
);

    logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] next_rd;
    logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] next_wr;
    logic                                  rd_adv;
    logic                                  wr_adv;

    // one slot kept free so full and empty differ
    function automatic logic is_full(
        input logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] wr,
        input logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] rd
    );
        logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] last;
        last = sram_fifo_pkg::SRAM_ADDR_W'(SRAM_DEPTH - 1);
        if (wr == last)
            return (rd == '0);
        return (wr + 1'b1 == rd);
    endfunction

    assign next_rd = (rd_ptr == sram_fifo_pkg::SRAM_ADDR_W'(SRAM_DEPTH - 1)) ? '0
                   : rd_ptr + 1'b1;
    assign next_wr = (wr_ptr == sram_fifo_pkg::SRAM_ADDR_W'(SRAM_DEPTH - 1)) ? '0
                   : wr_ptr + 1'b1;

    assign empty  = (wr_ptr == rd_ptr);
    assign full   = is_full(wr_ptr, rd_ptr);
    assign rd_adv = read_sram && !empty;
    assign wr_adv = write_sram && !full;

    always_ff @(posedge BUS_CLK) begin
        if (local_rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            full_reg <= 1'b0;
        end else begin
            if (rd_adv)
                rd_ptr <= next_rd;
            if (wr_adv)
                wr_ptr <= next_wr;
            // reads and writes never share a cycle
            if (rd_adv)
                full_reg <= is_full(wr_ptr, next_rd);
            else if (wr_adv)
                full_reg <= is_full(next_wr, rd_ptr);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (local_rst)
            size <= '0;
        else if (wr_ptr >= rd_ptr)
            size <= sram_fifo_pkg::SIZE_W'(wr_ptr - rd_ptr) + sram_fifo_pkg::SIZE_W'(hold);
        else
            size <= sram_fifo_pkg::SIZE_W'(wr_ptr) + sram_fifo_pkg::SIZE_W'(SRAM_DEPTH)
                  - sram_fifo_pkg::SIZE_W'(rd_ptr) + sram_fifo_pkg::SIZE_W'(hold);
    end

endmodule

// File: hdl/sram_read_fsm.sv
// sram_read_fsm
// fetches halfwords from the SRAM ahead of the USB reader and hands
// them out one byte at a time, low byte first
`timescale 1ns/100ps

module sram_read_fsm (
    input  logic                                 BUS_CLK,
    input  logic                                 local_rst,
    input  logic                                 empty,
    input  logic                                 usb_read,
    input  logic [sram_fifo_pkg::SRAM_DATA_W-1:0] sram_din,
    output logic                                 read_sram,
    output logic [7:0]                           usb_data,
    output logic                                 read_error_strobe,
    output logic                                 hold
);

    sram_fifo_pkg::read_state_e            state;
    sram_fifo_pkg::read_state_e            state_nxt;
    logic                                  usb_read_dly;
    logic                                  byte_sel;  // 1 = high byte shown
    logic [sram_fifo_pkg::SRAM_DATA_W-1:0] word_q;

    always_ff @(posedge BUS_CLK) begin
        if (local_rst)
            state <= sram_fifo_pkg::READ_TRY;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            sram_fifo_pkg::READ_TRY:
                if (!empty)
                    state_nxt = sram_fifo_pkg::READ_WORD;
            sram_fifo_pkg::READ_WORD:
                state_nxt = empty ? sram_fifo_pkg::READ_TRY : sram_fifo_pkg::READ_HOLD;
            sram_fifo_pkg::READ_HOLD:
                // word fully consumed, fetch the next or go idle
                if (usb_read && byte_sel)
                    state_nxt = empty ? sram_fifo_pkg::READ_TRY : sram_fifo_pkg::READ_WORD;
            default:
                state_nxt = sram_fifo_pkg::READ_TRY;
        endcase
    end

    assign read_sram = (state == sram_fifo_pkg::READ_WORD);
    assign hold      = (state == sram_fifo_pkg::READ_HOLD);

    always_ff @(posedge BUS_CLK) begin
        if (local_rst) begin
            usb_read_dly <= 1'b0;
            byte_sel     <= 1'b0;
        end else begin
            usb_read_dly <= usb_read;
            if (read_sram)
                byte_sel <= 1'b0; // fresh word starts at the low byte
            else if (usb_read_dly)
                byte_sel <= !byte_sel;
        end
    end

    // SRAM drives io during the read cycle, sample at its end
    always_ff @(posedge BUS_CLK) begin
        if (read_sram)
            word_q <= sram_din;
    end

    assign usb_data = byte_sel ? word_q[15:8] : word_q[7:0];

    // a held word is still valid data even with the SRAM drained
    assign read_error_strobe = usb_read && empty && !hold;

endmodule

// File: hdl/sram_write_path.sv
// sram_write_path
// moves input buffer words into the SRAM as two halfwords, low half
// first, and drives the SRAM pins; reads win over writes
`timescale 1ns/100ps

module sram_write_path (
    input  logic                                 wr_ptr0,
    input  logic                                 buf_empty,
    input  logic [31:0]                          buf_data,
    input  logic                                 full,
    input  logic                                 full_reg,
    input  logic                                 read_sram,
    output logic                                 write_sram,
    output logic                                 buf_pop,
    inout  wire  [sram_fifo_pkg::SRAM_DATA_W-1:0] sram_io,
    output logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] sram_a,
    input  logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] rd_ptr,
    input  logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] wr_ptr,
    output logic                                 sram_oe_b,
    output logic                                 sram_we_b
);

    logic [sram_fifo_pkg::SRAM_DATA_W-1:0] half_data;

    assign write_sram = !buf_empty && !full_reg && !read_sram;

    // word leaves the buffer once its high half goes out
    assign buf_pop = write_sram && !full && wr_ptr0;

    assign half_data = wr_ptr0 ? buf_data[31:16] : buf_data[15:0];

    assign sram_a    = read_sram ? rd_ptr : wr_ptr;
    assign sram_io   = write_sram ? half_data : 'z;
    assign sram_oe_b = !read_sram;
    assign sram_we_b = !write_sram; // level, stored on the clock edge

endmodule

// File: hdl/sram_fifo_top.sv
// sram_fifo_top
// SRAM backed FIFO: 32-bit stream in, bytes out to the USB side,
// 16-bit asynchronous SRAM used as ring buffer, 8-bit register bus
`timescale 1ns/100ps

module sram_fifo_top #(
    parameter int SRAM_DEPTH = 1 << sram_fifo_pkg::SRAM_ADDR_W
) (
    input  logic                                 BUS_CLK,
    input  logic                                 RST,
    input  logic [15:0]                          bus_add,
    input  logic [7:0]                           bus_data_in,
    input  logic                                 bus_wr,
    input  logic                                 bus_rd,  // readback runs every cycle
    output logic [7:0]                           bus_data_out,
    output logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] sram_a,
    inout  wire  [sram_fifo_pkg::SRAM_DATA_W-1:0] sram_io,
    output logic                                 sram_oe_b,
    output logic                                 sram_we_b,
    input  logic                                 usb_read,
    output logic [7:0]                           usb_data,
    output logic                                 fifo_read_next_out,
    input  logic                                 fifo_empty_in,
    input  logic [31:0]                          fifo_data,
    output logic                                 fifo_not_empty,
    output logic                                 fifo_full,
    output logic                                 fifo_near_full,
    output logic                                 fifo_read_error
);

    logic                                  local_rst;
    logic                                  read_sram, write_sram;
    logic                                  read_error_strobe;
    logic                                  hold;
    logic                                  empty, full, full_reg;
    logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] rd_ptr, wr_ptr;
    logic [sram_fifo_pkg::SIZE_W-1:0]      size;
    logic                                  buf_empty, buf_full, buf_pop;
    logic [31:0]                           buf_data;

    assign fifo_read_next_out = !buf_full;
    assign fifo_not_empty     = !empty;
    assign fifo_full          = full;

    sram_fifo_regs #(.SRAM_DEPTH(SRAM_DEPTH)) i_regs (
        .BUS_CLK, .RST, .bus_add, .bus_data_in, .bus_wr, .bus_data_out,
        .local_rst, .size, .read_error_strobe, .fifo_near_full, .fifo_read_error
    );

    sram_fifo_inbuf i_inbuf (
        .BUS_CLK, .local_rst, .wr_en(!fifo_empty_in), .din(fifo_data),
        .rd_en(buf_pop), .dout(buf_data), .empty(buf_empty), .full(buf_full)
    );

    sram_ptr_counter #(.SRAM_DEPTH(SRAM_DEPTH)) i_ptr (
        .BUS_CLK, .local_rst, .read_sram, .write_sram, .rd_ptr, .wr_ptr,
        .empty, .full, .full_reg, .hold, .size
    );

    sram_read_fsm i_read (
        .BUS_CLK, .local_rst, .empty, .usb_read, .sram_din(sram_io),
        .read_sram, .usb_data, .read_error_strobe, .hold
    );

    sram_write_path i_write (
        .wr_ptr0(wr_ptr[0]), .buf_empty, .buf_data, .full, .full_reg, .read_sram,
        .write_sram, .buf_pop, .sram_io, .sram_a, .rd_ptr, .wr_ptr,
        .sram_oe_b, .sram_we_b
    );

endmodule

// File: verif/sram_model.sv
// sram_model
// behavioral 16-bit asynchronous SRAM for simulation
// reads are combinational while oe_b is low, writes land on the clock edge
`timescale 1ns/100ps

module sram_model #(
    parameter int DEPTH = 64
) (
    input  logic                                 BUS_CLK,
    input  logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] sram_a,
    inout  wire  [sram_fifo_pkg::SRAM_DATA_W-1:0] sram_io,
    input  logic                                 sram_oe_b,
    input  logic                                 sram_we_b
);

    logic [sram_fifo_pkg::SRAM_DATA_W-1:0] mem [DEPTH];

    assign sram_io = (!sram_oe_b && sram_we_b) ? mem[sram_a] : 'z;

    always_ff @(posedge BUS_CLK) begin
        if (!sram_we_b)
            mem[sram_a] <= sram_io; // we_b is a level, sampled at the edge
    end

endmodule

// File: verif/sram_fifo_assert.sv
// sram_fifo_assert
// concurrent checks bound into the SRAM FIFO top level
`timescale 1ns/100ps

module sram_fifo_assert (
    input logic       BUS_CLK,
    input logic       RST,
    input logic       local_rst,
    input logic       sram_oe_b,
    input logic       sram_we_b,
    input logic       fifo_full,
    input logic       fifo_not_empty,
    input logic [7:0] err_cnt
);

    // shared SRAM bus, one direction per cycle
    a_strobe_excl: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(!sram_oe_b && !sram_we_b))
        else $error("SRAM output enable and write enable low together");

    a_full_not_empty: assert property (@(posedge BUS_CLK) disable iff (RST)
        fifo_full |-> fifo_not_empty)
        else $error("full flag raised on an empty ring buffer");

    // counter sticks at 255 until a reset
    a_err_saturate: assert property (@(posedge BUS_CLK) disable iff (RST)
        (err_cnt == 8'hff && !local_rst) |=> (err_cnt == 8'hff))
        else $error("read error counter left 255 without a reset");

endmodule

bind sram_fifo_top sram_fifo_assert i_assert (
    .BUS_CLK, .RST, .local_rst, .sram_oe_b, .sram_we_b, .fifo_full,
    .fifo_not_empty, .err_cnt(i_regs.err_cnt)
);

// File: verif/tb_sram_fifo.sv
// tb_sram_fifo
// directed testbench of the SRAM FIFO: byte order, size readback,
// read errors, near-full hysteresis, full flag and back-pressure
`timescale 1ns/100ps

module tb_sram_fifo;

    localparam int DEPTH   = 64;
    localparam int TIMEOUT = 2000; // cycles allowed per wait

    logic                                  BUS_CLK = 1'b0;
    logic                                  RST;
    logic [15:0]                           bus_add;
    logic [7:0]                            bus_data_in;
    logic                                  bus_wr;
    logic                                  bus_rd;
    logic [7:0]                            bus_data_out;
    logic [sram_fifo_pkg::SRAM_ADDR_W-1:0] sram_a;
    wire  [sram_fifo_pkg::SRAM_DATA_W-1:0] sram_io;
    logic                                  sram_oe_b;
    logic                                  sram_we_b;
    logic                                  usb_read;
    logic [7:0]                            usb_data;
    logic                                  fifo_read_next_out;
    logic                                  fifo_empty_in;
    logic [31:0]                           fifo_data;
    logic                                  fifo_not_empty;
    logic                                  fifo_full;
    logic                                  fifo_near_full;
    logic                                  fifo_read_error;

    logic [31:0] lfsr = 32'h48db_2461;
    logic [31:0] expected_q[$]; // words pushed and not yet read back

    always #10 BUS_CLK = !BUS_CLK;

    sram_fifo_top #(.SRAM_DEPTH(DEPTH)) uut (.*);

    sram_model #(.DEPTH(DEPTH)) i_sram (
        .BUS_CLK, .sram_a, .sram_io, .sram_oe_b, .sram_we_b
    );

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
            fail_stop($sformatf("ERROR %s: got %h, expected %h", name, actual, expected));
    endtask

    task automatic step();
        @(posedge BUS_CLK);
        #2; // drive and sample just after the edge
    endtask

    // Galois LFSR, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        step();
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        bus_add = addr;
        bus_rd  = 1'b1;
        step(); // readback registered here
        data   = bus_data_out;
        bus_rd = 1'b0;
    endtask

    task automatic soft_reset();
        bus_write(sram_fifo_pkg::REG_RESET, 8'h00);
        expected_q.delete();
    endtask

    task automatic push_word(input logic [31:0] w);
        int n = 0;
        fifo_data     = w;
        fifo_empty_in = 1'b0;
        while (!fifo_read_next_out) begin
            step();
            n++;
            if (n > TIMEOUT)
                fail_stop("source word never accepted, input buffer stayed full");
        end
        step(); // word taken on this edge
        fifo_empty_in = 1'b1;
        expected_q.push_back(w);
    endtask

    task automatic push_random(input int count);
        logic [31:0] w;
        for (int i = 0; i < count; i++) begin
            random_word(w);
            push_word(w);
        end
    endtask

    // read attempts with nothing to hand out
    task automatic pulse_usb_read(input int count);
        for (int i = 0; i < count; i++) begin
            usb_read = 1'b1;
            step();
            usb_read = 1'b0;
            step();
        end
    endtask

    task automatic wait_word_held();
        int n = 0;
        while (!uut.hold) begin
            step();
            n++;
            if (n > TIMEOUT)
                fail_stop("no halfword reached the USB side reader");
        end
    endtask

    // writer drained and a halfword held, then size and near-full lag
    task automatic wait_idle();
        int n = 0;
        while (!(uut.hold && uut.buf_empty)) begin
            step();
            n++;
            if (n > TIMEOUT)
                fail_stop("write path never went idle");
        end
        step();
        step();
    endtask

    task automatic read_byte(input logic [7:0] expected);
        check("usb_data", 32'(usb_data), 32'(expected));
        usb_read = 1'b1;
        step();
        usb_read = 1'b0;
        step();
        step();
    endtask

    task automatic read_word();
        logic [31:0] w;
        if (expected_q.size() == 0)
            fail_stop("read requested with no word left to compare against");
        w = expected_q.pop_front();
        for (int h = 0; h < 2; h++) begin
            wait_word_held();
            read_byte(w[16*h +: 8]);     // low byte of the halfword first
            read_byte(w[16*h+8 +: 8]);
        end
    endtask

    task automatic check_size(input int bytes);
        logic [7:0] b;
        bus_read(sram_fifo_pkg::REG_SIZE0, b);
        check("size[7:0]", 32'(b), 32'(bytes[7:0]));
        bus_read(sram_fifo_pkg::REG_SIZE1, b);
        check("size[15:8]", 32'(b), 32'(bytes[15:8]));
        bus_read(sram_fifo_pkg::REG_SIZE2, b);
        check("size[23:16]", 32'(b), 32'(bytes[23:16]));
    endtask

    task automatic test_data_order();
        soft_reset();
        push_random(8);
        repeat (8) read_word();
        check("fifo_read_error", fifo_read_error, 1'b0);
    endtask

    task automatic test_size_readback();
        soft_reset();
        push_random(9);
        wait_idle();
        check_size(4 * 9);
        check("fifo_not_empty", fifo_not_empty, 1'b1);
        check("fifo_full", fifo_full, 1'b0);
        repeat (9) read_word();
        check_size(0);
        check("fifo_not_empty", fifo_not_empty, 1'b0);
    endtask

    task automatic test_read_error();
        logic [7:0] b;
        soft_reset();
        pulse_usb_read(3);
        bus_read(sram_fifo_pkg::REG_ERRCNT, b);
        check("err_cnt", 32'(b), 32'd3);
        check("fifo_read_error", fifo_read_error, 1'b1);
        pulse_usb_read(260); // well past the 8-bit limit
        bus_read(sram_fifo_pkg::REG_ERRCNT, b);
        check("err_cnt", 32'(b), 32'hff);
        soft_reset();
        bus_read(sram_fifo_pkg::REG_ERRCNT, b);
        check("err_cnt", 32'(b), 32'd0);
        check("fifo_read_error", fifo_read_error, 1'b0);
    endtask

    task automatic test_near_full();
        int set_level;
        int clear_level;
        set_level   = ((127 + 1) * DEPTH) >> 8; // halfwords
        clear_level = ((63 + 1) * DEPTH) >> 8;
        soft_reset();
        bus_write(sram_fifo_pkg::REG_SIZE0, 8'd127);
        bus_write(sram_fifo_pkg::REG_SIZE1, 8'd63);
        push_random(15);
        wait_idle();
        check("fifo_near_full", fifo_near_full, 32'(2 * 15 >= set_level));
        push_random(1);
        wait_idle();
        check("fifo_near_full", fifo_near_full, 32'(2 * 16 >= set_level));
        repeat (7) read_word();
        wait_idle();
        check("fifo_near_full", fifo_near_full, 32'(!(2 * 9 <= clear_level)));
        read_word(); // lower level reached at 8 words
        wait_idle();
        check("fifo_near_full", fifo_near_full, 32'(!(2 * 8 <= clear_level)));
    endtask

    task automatic test_full();
        int n = 0;
        soft_reset();
        push_random(48); // 32 words on the SRAM side, 16 in the input buffer
        while (!fifo_full) begin
            step();
            n++;
            if (n > TIMEOUT)
                fail_stop("full flag never rose with the writer running");
        end
        step();
        step();
        check_size(2 * DEPTH); // 63 stored halfwords plus the held one
        check("fifo_read_next_out", fifo_read_next_out, 1'b0);
        read_word();
        push_random(1);
        repeat (48) read_word();
        check("fifo_not_empty", fifo_not_empty, 1'b0);
        check("fifo_full", fifo_full, 1'b0);
        check("fifo_read_next_out", fifo_read_next_out, 1'b1);
    endtask

    initial begin
        RST           = 1'b1;
        bus_add       = '0;
        bus_data_in   = '0;
        bus_wr        = 1'b0;
        bus_rd        = 1'b0;
        usb_read      = 1'b0;
        fifo_empty_in = 1'b1;
        fifo_data     = '0;
        repeat (2) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;
        test_data_order();
        test_size_readback();
        test_read_error();
        test_near_full();
        test_full();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog.f
hdl/sram_fifo_pkg.sv
hdl/sram_fifo_regs.sv
hdl/sram_fifo_inbuf.sv
hdl/sram_ptr_counter.sv
hdl/sram_read_fsm.sv
hdl/sram_write_path.sv
hdl/sram_fifo_top.sv
verif/sram_model.sv
verif/sram_fifo_assert.sv
verif/tb_sram_fifo.sv

// File: Bender.yml
package:
  name: sram_fifo

sources:
  - files:
      - hdl/sram_fifo_pkg.sv
      - hdl/sram_fifo_regs.sv
      - hdl/sram_fifo_inbuf.sv
      - hdl/sram_ptr_counter.sv
      - hdl/sram_read_fsm.sv
      - hdl/sram_write_path.sv
      - hdl/sram_fifo_top.sv
  - target: simulation
    files:
      - verif/sram_model.sv
      - verif/sram_fifo_assert.sv
      - verif/tb_sram_fifo.sv
